//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // data and address width
    localparam int xlen = 64;

    // machine csr numbers in use
    typedef enum logic [11:0] {
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mip       = 12'h344,
        csr_mcycle    = 12'hB00,
        csr_minstret  = 12'hB02,
        csr_mvendorid = 12'hF11,
        csr_marchid   = 12'hF12,
        csr_mimpid    = 12'hF13,
        csr_mhartid   = 12'hF14
    } csr_addr_e;

    // decoded system operation
    typedef enum logic [2:0] {
        sys_none,
        sys_csrrw,
        sys_csrrs,
        sys_csrrc,
        sys_ecall,
        sys_ebreak,
        sys_mret
    } sys_op_e;

    // mcause values
    localparam logic [xlen-1:0] cause_ecall_m    = 64'd11;
    localparam logic [xlen-1:0] cause_breakpoint = 64'd3;
    localparam logic [xlen-1:0] cause_mtimer_irq = 64'h8000_0000_0000_0007;

    // writable bits
    localparam logic [xlen-1:0] mstatus_wmask = 64'h88;
    localparam logic [xlen-1:0] mie_wmask     = 64'h80;
    localparam logic [xlen-1:0] mtvec_wmask   = ~64'h3;

    // reset and constant values
    localparam logic [xlen-1:0] mstatus_reset = 64'h1800;
    localparam logic [xlen-1:0] mie_reset     = 64'h80;
    localparam logic [xlen-1:0] mtvec_reset   = 64'h8000_0520;
    // MXL = 2, I extension only
    localparam logic [xlen-1:0] misa_value    = 64'h8000_0000_0000_0100;
    localparam logic [xlen-1:0] marchid_value = 64'd1;

    // bit positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mtip_bit         = 7;

endpackage

`default_nettype wire

//--- src/sys_decode.sv
`timescale 1ns/1ns
`default_nettype none

module sys_decode (
    input  wire logic [31:0]                inst,
    input  wire logic [csr_pkg::xlen-1:0]   rs1_data,
    output csr_pkg::sys_op_e                op,
    output logic [11:0]                     csr_addr,
    output logic [csr_pkg::xlen-1:0]        csr_wdata
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic [4:0]  rs1_field;
    logic [4:0]  rd_field;
    logic        is_system;
    logic        regs_zero;

    assign opcode    = inst[6:0];
    assign rd_field  = inst[11:7];
    assign funct3    = inst[14:12];
    assign rs1_field = inst[19:15];
    assign funct12   = inst[31:20];

    assign is_system = (opcode == 7'b1110011);
    // priv forms need rd and rs1 zero
    assign regs_zero = (rd_field == 5'd0) && (rs1_field == 5'd0);

    always_comb begin
        op = csr_pkg::sys_none;
        if (is_system) begin
            case (funct3)
                3'b000: begin
                    if (regs_zero) begin
                        case (funct12)
                            12'h000: op = csr_pkg::sys_ecall;
                            12'h001: op = csr_pkg::sys_ebreak;
                            12'h302: op = csr_pkg::sys_mret;
                            default: op = csr_pkg::sys_none;
                        endcase
                    end
                end
                3'b001, 3'b101: op = csr_pkg::sys_csrrw;
                3'b010, 3'b110: op = csr_pkg::sys_csrrs;
                3'b011, 3'b111: op = csr_pkg::sys_csrrc;
                default: op = csr_pkg::sys_none;
            endcase
        end
    end

    assign csr_addr = funct12;

    // funct3[2] selects the zimm form
    always_comb begin
        if (funct3[2]) begin
            csr_wdata = {{(csr_pkg::xlen-5){1'b0}}, rs1_field};
        end else begin
            csr_wdata = rs1_data;
        end
    end

endmodule

`default_nettype wire

//--- src/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       inst_valid,
    input  wire csr_pkg::sys_op_e           op,
    input  wire logic [11:0]                csr_addr,
    input  wire logic [csr_pkg::xlen-1:0]   csr_wdata,
    input  wire logic [csr_pkg::xlen-1:0]   pc,
    input  wire logic                       mtip,
    output logic [csr_pkg::xlen-1:0]        csr_rdata,
    output logic                            redirect,
    output logic [csr_pkg::xlen-1:0]        redirect_pc,
    output logic                            irq_pending
);

    logic [csr_pkg::xlen-1:0] mstatus_r;
    logic [csr_pkg::xlen-1:0] mtvec_r;
    logic [csr_pkg::xlen-1:0] mepc_r;
    logic [csr_pkg::xlen-1:0] mcause_r;
    logic [csr_pkg::xlen-1:0] mie_r;
    logic [csr_pkg::xlen-1:0] mscratch_r;
    logic [csr_pkg::xlen-1:0] mcycle_r;
    logic [csr_pkg::xlen-1:0] minstret_r;

    logic [csr_pkg::xlen-1:0] mip_val;
    logic [csr_pkg::xlen-1:0] csr_new;
    logic [csr_pkg::xlen-1:0] trap_cause;

    logic exec;
    logic irq_take;
    logic trap_en;
    logic mret_en;
    logic csr_we;
    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mie;
    logic wr_mscratch;
    logic wr_mcycle;
    logic wr_minstret;

    // interrupt replaces the incoming instruction
    assign irq_pending = mstatus_r[csr_pkg::mstatus_mie_bit] & mie_r[csr_pkg::mtip_bit] & mtip;
    assign irq_take    = inst_valid & irq_pending;
    assign exec        = inst_valid & ~irq_pending;

    assign trap_en = irq_take
                   | (exec & (op == csr_pkg::sys_ecall || op == csr_pkg::sys_ebreak));
    assign mret_en = exec & (op == csr_pkg::sys_mret);

    // set/clear with a zero operand is a pure read
    assign csr_we = exec & ((op == csr_pkg::sys_csrrw)
                  | ((op == csr_pkg::sys_csrrs || op == csr_pkg::sys_csrrc) & (|csr_wdata)));

    assign wr_mstatus  = csr_we && csr_addr == csr_pkg::csr_mstatus;
    assign wr_mtvec    = csr_we && csr_addr == csr_pkg::csr_mtvec;
    assign wr_mepc     = csr_we && csr_addr == csr_pkg::csr_mepc;
    assign wr_mcause   = csr_we && csr_addr == csr_pkg::csr_mcause;
    assign wr_mie      = csr_we && csr_addr == csr_pkg::csr_mie;
    assign wr_mscratch = csr_we && csr_addr == csr_pkg::csr_mscratch;
    assign wr_mcycle   = csr_we && csr_addr == csr_pkg::csr_mcycle;
    assign wr_minstret = csr_we && csr_addr == csr_pkg::csr_minstret;

    always_comb begin
        mip_val = '0;
        mip_val[csr_pkg::mtip_bit] = mtip;
    end

    // old value of the addressed csr
    always_comb begin
        case (csr_pkg::csr_addr_e'(csr_addr))
            csr_pkg::csr_mstatus:   csr_rdata = mstatus_r;
            csr_pkg::csr_misa:      csr_rdata = csr_pkg::misa_value;
            csr_pkg::csr_mie:       csr_rdata = mie_r;
            csr_pkg::csr_mtvec:     csr_rdata = mtvec_r;
            csr_pkg::csr_mscratch:  csr_rdata = mscratch_r;
            csr_pkg::csr_mepc:      csr_rdata = mepc_r;
            csr_pkg::csr_mcause:    csr_rdata = mcause_r;
            csr_pkg::csr_mip:       csr_rdata = mip_val;
            csr_pkg::csr_mcycle:    csr_rdata = mcycle_r;
            csr_pkg::csr_minstret:  csr_rdata = minstret_r;
            csr_pkg::csr_marchid:   csr_rdata = csr_pkg::marchid_value;
            default:                csr_rdata = '0;
        endcase
    end

    always_comb begin
        case (op)
            csr_pkg::sys_csrrw: csr_new = csr_wdata;
            csr_pkg::sys_csrrs: csr_new = csr_rdata | csr_wdata;
            default:            csr_new = csr_rdata & ~csr_wdata;
        endcase
    end

    always_comb begin
        if (irq_take) begin
            trap_cause = csr_pkg::cause_mtimer_irq;
        end else if (op == csr_pkg::sys_ebreak) begin
            trap_cause = csr_pkg::cause_breakpoint;
        end else begin
            trap_cause = csr_pkg::cause_ecall_m;
        end
    end

    assign redirect    = trap_en | mret_en;
    assign redirect_pc = trap_en ? mtvec_r : mepc_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_r <= csr_pkg::mstatus_reset;
        end else if (wr_mstatus) begin
            mstatus_r <= csr_new & csr_pkg::mstatus_wmask;
        end else if (trap_en) begin
            mstatus_r[csr_pkg::mstatus_mpie_bit] <= mstatus_r[csr_pkg::mstatus_mie_bit];
            mstatus_r[csr_pkg::mstatus_mie_bit]  <= 1'b0;
        end else if (mret_en) begin
            mstatus_r[csr_pkg::mstatus_mie_bit]  <= mstatus_r[csr_pkg::mstatus_mpie_bit];
            mstatus_r[csr_pkg::mstatus_mpie_bit] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_r <= csr_pkg::mtvec_reset;
        end else if (wr_mtvec) begin
            mtvec_r <= csr_new & csr_pkg::mtvec_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_r <= csr_pkg::mie_reset;
        end else if (wr_mie) begin
            mie_r <= csr_new & csr_pkg::mie_wmask;
        end
    end

    // trap entry writes mepc and mcause together
    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_r   <= '0;
            mcause_r <= '0;
        end else if (trap_en) begin
            mepc_r   <= pc;
            mcause_r <= trap_cause;
        end else begin
            if (wr_mepc) begin
                mepc_r <= csr_new;
            end
            if (wr_mcause) begin
                mcause_r <= csr_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscratch) begin
            mscratch_r <= csr_new;
        end
    end

    // counters, a write wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_r <= '0;
        end else if (wr_mcycle) begin
            mcycle_r <= csr_new;
        end else begin
            mcycle_r <= mcycle_r + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_r <= '0;
        end else if (wr_minstret) begin
            minstret_r <= csr_new;
        end else if (exec) begin
            minstret_r <= minstret_r + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/clint_timer.sv
`timescale 1ns/1ns
`default_nettype none

module clint_timer (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       mtimecmp_we,
    input  wire logic [csr_pkg::xlen-1:0]   mtimecmp_wdata,
    output logic                            mtip
);

    logic [csr_pkg::xlen-1:0] mtime_r;
    logic [csr_pkg::xlen-1:0] mtimecmp_r;

    // free running, one tick per clock
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_r <= '0;
        end else begin
            mtime_r <= mtime_r + 1'b1;
        end
    end

    // all ones keeps the timer quiet after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_r <= '1;
        end else if (mtimecmp_we) begin
            mtimecmp_r <= mtimecmp_wdata;
        end
    end

    // level, follows a new compare value right away
    assign mtip = (mtime_r >= mtimecmp_r);

endmodule

`default_nettype wire

//--- src/csr_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       inst_valid,
    input  wire logic [31:0]                inst,
    input  wire logic [csr_pkg::xlen-1:0]   rs1_data,
    input  wire logic [csr_pkg::xlen-1:0]   pc,
    input  wire logic                       mtimecmp_we,
    input  wire logic [csr_pkg::xlen-1:0]   mtimecmp_wdata,
    output logic [csr_pkg::xlen-1:0]        csr_rdata,
    output logic                            redirect,
    output logic [csr_pkg::xlen-1:0]        redirect_pc,
    output logic                            irq_pending
);

    csr_pkg::sys_op_e           op;
    logic [11:0]                csr_addr;
    logic [csr_pkg::xlen-1:0]   csr_wdata;
    logic                       mtip;

    sys_decode u_decode (
        .inst       (inst),
        .rs1_data   (rs1_data),
        .op         (op),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .op          (op),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .pc          (pc),
        .mtip        (mtip),
        .csr_rdata   (csr_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .irq_pending (irq_pending)
    );

    clint_timer u_timer (
        .clk            (clk),
        .rst            (rst),
        .mtimecmp_we    (mtimecmp_we),
        .mtimecmp_wdata (mtimecmp_wdata),
        .mtip           (mtip)
    );

endmodule

`default_nettype wire

//--- verif/csr_props.sv
`timescale 1ns/1ns
`default_nettype none

module csr_props (
    input wire logic                       clk,
    input wire logic                       rst,
    input wire logic                       inst_valid,
    input wire csr_pkg::sys_op_e           op,
    input wire logic                       irq_pending,
    input wire logic                       redirect,
    input wire logic [csr_pkg::xlen-1:0]   redirect_pc,
    input wire logic [csr_pkg::xlen-1:0]   mtvec_r,
    input wire logic [csr_pkg::xlen-1:0]   mstatus_r
);

    logic trap_valid;

    // ecall, ebreak or a taken timer interrupt
    assign trap_valid = inst_valid
                      & (irq_pending | (op == csr_pkg::sys_ecall) | (op == csr_pkg::sys_ebreak));

    no_redirect_when_idle: assert property (@(posedge clk) disable iff (rst)
        !inst_valid |-> !redirect)
        else $error("redirect raised without a valid instruction");

    trap_goes_to_mtvec: assert property (@(posedge clk) disable iff (rst)
        trap_valid |-> (redirect_pc == mtvec_r))
        else $error("trap redirect does not point at mtvec");

    mie_cleared_after_trap: assert property (@(posedge clk) disable iff (rst)
        trap_valid |=> !mstatus_r[csr_pkg::mstatus_mie_bit])
        else $error("mstatus.MIE still set after trap entry");

endmodule

bind csr_file csr_props u_props (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .op          (op),
    .irq_pending (irq_pending),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mtvec_r     (mtvec_r),
    .mstatus_r   (mstatus_r)
);

`default_nettype wire

//--- verif/csr_tb.sv
`timescale 1ns/1ns
`default_nettype none

module csr_tb;

    localparam logic [2:0] f_rw = 3'd1;
    localparam logic [2:0] f_rs = 3'd2;
    localparam logic [2:0] f_rc = 3'd3;
    localparam logic [63:0] clk_period = 64'd10;
    // the tests take about 140 cycles
    localparam int watchdog_ns = 20000;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [63:0] rs1_data;
    logic [63:0] pc;
    logic        mtimecmp_we;
    logic [63:0] mtimecmp_wdata;
    logic [63:0] csr_rdata;
    logic        redirect;
    logic [63:0] redirect_pc;
    logic        irq_pending;

    logic [15:0] lfsr;
    int          errors;
    logic [63:0] got_rdata;
    logic        got_redirect;
    logic [63:0] got_rpc;
    logic [63:0] got_time;

    // reference copies of the machine csrs
    logic [63:0] m_mstatus;
    logic [63:0] m_mtvec;
    logic [63:0] m_mie;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic [63:0] m_mscratch;

    csr_unit_top UUT (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .rs1_data       (rs1_data),
        .pc             (pc),
        .mtimecmp_we    (mtimecmp_we),
        .mtimecmp_wdata (mtimecmp_wdata),
        .csr_rdata      (csr_rdata),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .irq_pending    (irq_pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("Something failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] csr_inst(input logic [2:0] f3, input logic [11:0] addr,
                                             input logic [4:0] rs1f);
        return {addr, rs1f, f3, 5'd10, 7'b1110011};
    endfunction

    function automatic logic [31:0] priv_inst(input logic [11:0] f12);
        return {f12, 5'd0, 3'd0, 5'd0, 7'b1110011};
    endfunction

    // write, set or clear on the reference copy
    function automatic logic [63:0] csr_apply(input logic [2:0] f3, input logic [63:0] old,
                                              input logic [63:0] opnd);
        case (f3[1:0])
            2'd1:    return opnd;
            2'd2:    return old | opnd;
            default: return old & ~opnd;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic exec_inst(input logic [31:0] w, input logic [63:0] rs1,
                             input logic [63:0] p);
        @(negedge clk);
        inst_valid = 1'b1;
        inst = w;
        rs1_data = rs1;
        pc = p;
        // combinational outputs sampled mid low phase
        #2;
        got_rdata = csr_rdata;
        got_redirect = redirect;
        got_rpc = redirect_pc;
        got_time = $time;
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr,
                          input logic [63:0] opnd);
        if (f3[2]) begin
            exec_inst(csr_inst(f3, addr, opnd[4:0]), 64'd0, 64'h1000);
        end else begin
            exec_inst(csr_inst(f3, addr, 5'd1), opnd, 64'h1000);
        end
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [63:0] exp, input string what);
        csr_op(f_rs, addr, 64'd0);
        check_value(what, got_rdata, exp);
        check_flag({what, " redirect"}, got_redirect, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic set_mtimecmp(input logic [63:0] v);
        @(negedge clk);
        mtimecmp_we = 1'b1;
        mtimecmp_wdata = v;
        @(negedge clk);
        mtimecmp_we = 1'b0;
    endtask

    task automatic check_irq(input logic exp);
        #1;
        check_flag("irq_pending", irq_pending, exp);
    endtask

    task automatic model_trap(input logic [63:0] cause, input logic [63:0] p);
        m_mepc = p;
        m_mcause = cause;
        m_mstatus[7] = m_mstatus[3];
        m_mstatus[3] = 1'b0;
    endtask

    task automatic model_mret();
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
    endtask

    task automatic test_reset_values();
        m_mstatus = 64'h1800;
        m_mie = 64'h80;
        m_mtvec = 64'h8000_0520;
        read_csr(12'h300, m_mstatus, "mstatus");
        read_csr(12'h304, m_mie, "mie");
        read_csr(12'h305, m_mtvec, "mtvec");
        read_csr(12'h301, 64'h8000_0000_0000_0100, "misa");
        read_csr(12'hF12, 64'd1, "marchid");
        read_csr(12'hF11, 64'd0, "mvendorid");
        read_csr(12'hF13, 64'd0, "mimpid");
        read_csr(12'hF14, 64'd0, "mhartid");
        read_csr(12'h344, 64'd0, "mip");
        read_csr(12'h7C0, 64'd0, "unknown csr");
    endtask

    task automatic test_csr_ops();
        logic [63:0] w;
        logic [63:0] opnd;
        logic [2:0]  f3;
        rand_bits(64, w);
        csr_op(f_rw, 12'h340, w);
        m_mscratch = w;
        for (int i = 0; i < 6; i++) begin
            f3 = 3'(1 + i % 3);
            if (i >= 3) begin
                f3[2] = 1'b1;
                rand_bits(5, opnd);
            end else begin
                rand_bits(64, opnd);
            end
            csr_op(f3, 12'h340, opnd);
            check_value("mscratch old", got_rdata, m_mscratch);
            m_mscratch = csr_apply(f3, m_mscratch, opnd);
        end
        read_csr(12'h340, m_mscratch, "mscratch");
        rand_bits(64, w);
        csr_op(f_rw, 12'h305, w);
        check_value("mtvec old", got_rdata, m_mtvec);
        m_mtvec = w & ~64'h3;
        read_csr(12'h305, m_mtvec, "mtvec masked");
        rand_bits(64, w);
        csr_op(f_rw, 12'h300, w);
        check_value("mstatus old", got_rdata, m_mstatus);
        m_mstatus = w & 64'h88;
        read_csr(12'h300, m_mstatus, "mstatus masked");
        rand_bits(64, w);
        csr_op(f_rw, 12'h304, w);
        check_value("mie old", got_rdata, m_mie);
        m_mie = w & 64'h80;
        read_csr(12'h304, m_mie, "mie masked");
    endtask

    task automatic test_traps();
        csr_op(f_rw, 12'h300, 64'h8);
        m_mstatus = 64'h8;
        exec_inst(priv_inst(12'h000), 64'd0, 64'h2000_0100);
        check_flag("ecall redirect", got_redirect, 1'b1);
        check_value("ecall target", got_rpc, m_mtvec);
        model_trap(64'd11, 64'h2000_0100);
        read_csr(12'h341, m_mepc, "mepc after ecall");
        read_csr(12'h342, m_mcause, "mcause after ecall");
        read_csr(12'h300, m_mstatus, "mstatus after ecall");
        exec_inst(priv_inst(12'h302), 64'd0, 64'h2000_0200);
        check_flag("mret redirect", got_redirect, 1'b1);
        check_value("mret target", got_rpc, m_mepc);
        model_mret();
        read_csr(12'h300, m_mstatus, "mstatus after mret");
        exec_inst(priv_inst(12'h001), 64'd0, 64'h2000_0300);
        check_flag("ebreak redirect", got_redirect, 1'b1);
        check_value("ebreak target", got_rpc, m_mtvec);
        model_trap(64'd3, 64'h2000_0300);
        read_csr(12'h342, m_mcause, "mcause after ebreak");
        read_csr(12'h341, m_mepc, "mepc after ebreak");
        // with MPIE cleared, mret must copy a zero into MIE and set MPIE again
        csr_op(f_rc, 12'h300, 64'h80);
        m_mstatus = csr_apply(f_rc, m_mstatus, 64'h80);
        exec_inst(priv_inst(12'h302), 64'd0, 64'h2000_0400);
        check_flag("second mret redirect", got_redirect, 1'b1);
        check_value("second mret target", got_rpc, m_mepc);
        model_mret();
        read_csr(12'h300, m_mstatus, "mstatus after second mret");
    endtask

    task automatic test_counters();
        logic [63:0] a;
        logic [63:0] c1;
        logic [63:0] t1;
        logic [63:0] w;
        csr_op(f_rs, 12'hB02, 64'd0);
        a = got_rdata;
        repeat (3) read_csr(12'h340, m_mscratch, "mscratch");
        idle(5);
        read_csr(12'hB02, a + 64'd4, "minstret");
        csr_op(f_rs, 12'hB00, 64'd0);
        c1 = got_rdata;
        t1 = got_time;
        idle(7);
        csr_op(f_rs, 12'hB00, 64'd0);
        check_value("mcycle delta", got_rdata - c1, (got_time - t1) / clk_period);
        rand_bits(32, w);
        csr_op(f_rw, 12'hB00, w);
        t1 = got_time;
        idle(3);
        csr_op(f_rs, 12'hB00, 64'd0);
        check_value("mcycle after write", got_rdata,
                    w + (got_time - t1) / clk_period - 64'd1);
    endtask

    task automatic test_timer_irq();
        logic [63:0] a;
        csr_op(f_rw, 12'h300, 64'd0);
        m_mstatus = 64'd0;
        csr_op(f_rw, 12'h304, 64'h80);
        m_mie = 64'h80;
        set_mtimecmp(64'd0);
        read_csr(12'h344, 64'h80, "mip with timer due");
        check_irq(1'b0);
        csr_op(f_rs, 12'hB02, 64'd0);
        a = got_rdata;
        csr_op(f_rs, 12'h300, 64'h8);
        m_mstatus[3] = 1'b1;
        check_irq(1'b1);
        exec_inst(csr_inst(f_rs, 12'h340, 5'd1), 64'd0, 64'h2000_0500);
        check_flag("irq redirect", got_redirect, 1'b1);
        check_value("irq target", got_rpc, m_mtvec);
        model_trap(64'h8000_0000_0000_0007, 64'h2000_0500);
        check_irq(1'b0);
        read_csr(12'hB02, a + 64'd2, "minstret across irq");
        read_csr(12'h342, m_mcause, "mcause after irq");
        read_csr(12'h341, m_mepc, "mepc after irq");
        read_csr(12'h300, m_mstatus, "mstatus after irq");
        set_mtimecmp('1);
        read_csr(12'h344, 64'd0, "mip after mtimecmp reset");
    endtask

    initial begin
        errors = 0;
        lfsr = 16'd54877;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        rs1_data = '0;
        pc = '0;
        mtimecmp_we = 1'b0;
        mtimecmp_wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_values();
        test_csr_ops();
        test_traps();
        test_counters();
        test_timer_irq();
        $display("csr unit tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/csr_pkg.sv
src/sys_decode.sv
src/csr_file.sv
src/clint_timer.sv
src/csr_unit_top.sv
verif/csr_props.sv
verif/csr_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f tb.f -o csr_sim \
    && ./obj_dir/csr_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
